// ==== Makefile ====
# Verilator build and run of the Wishbone divider testbench

TOP = tb_wb_divider

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sim.f --Mdir obj_dir -o sim_tb
	-./obj_dir/sim_tb > sim.log 2>&1
	@cat sim.log
	@grep -qx "sim passed" sim.log || (echo "Simulation FAILED, see sim.log"; exit 1)
	@echo "Simulation PASSED"

clean:
	rm -rf obj_dir sim.log

// ==== divide.sv ====
`timescale 1ns/1ps

// Sequential non-restoring divider on unsigned operands, one quotient bit per clock
module divide #(
    parameter int DIV_WIDTH = fxp_pkg::DEFAULT_DATA_WIDTH + fxp_pkg::DEFAULT_QUANTIZED_BITS
)(
    input logic clock,
    input logic reset,
    div_if.divider div
);

    localparam int COUNT_WIDTH = $clog2(DIV_WIDTH + 1);

    typedef logic [DIV_WIDTH-1:0]   word_t;
    typedef logic [2*DIV_WIDTH:0]   eaq_t;    // {E, A, Q}
    typedef logic [COUNT_WIDTH-1:0] count_t;

    typedef enum logic [1:0] {
        st_idle,
        st_iterate,
        st_finish
    } state_t;

    state_t state, state_next;
    count_t count, count_next;
    eaq_t   eaq, eaq_next;
    word_t  divisor_q, divisor_next;
    logic [DIV_WIDTH:0] partial;  // Signed partial remainder, E and A

    // ----------------------------------------
    // State registers
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            count <= '0;
        end else begin
            state <= state_next;
            count <= count_next;
        end
    end

    always_ff @(posedge clock) begin
        eaq       <= eaq_next;
        divisor_q <= divisor_next;
    end

    // ----------------------------------------
    // Next state and datapath
    // ----------------------------------------
    always_comb begin
        state_next   = state;
        count_next   = count;
        eaq_next     = eaq;
        divisor_next = divisor_q;
        partial      = '0;

        case (state)
            st_idle: begin
                if (div.start) begin
                    divisor_next = div.divisor;
                    eaq_next     = {1'b0, word_t'(0), div.dividend};
                    count_next   = '0;
                    state_next   = st_iterate;
                end
            end

            st_iterate: begin
                eaq_next = eaq << 1;
                // Sign of the previous remainder picks add or subtract
                if (eaq[2*DIV_WIDTH])
                    partial = eaq_next[2*DIV_WIDTH:DIV_WIDTH] + {1'b0, divisor_q};
                else
                    partial = eaq_next[2*DIV_WIDTH:DIV_WIDTH] - {1'b0, divisor_q};
                eaq_next[0] = ~partial[DIV_WIDTH];
                count_next  = count + 1'b1;
                if (count == count_t'(DIV_WIDTH - 1)) begin
                    if (partial[DIV_WIDTH])
                        partial = partial + {1'b0, divisor_q};  // Final correction
                    state_next = st_finish;
                end
                eaq_next[2*DIV_WIDTH:DIV_WIDTH] = partial;
            end

            st_finish: state_next = st_idle;

            default: state_next = st_idle;
        endcase
    end

    assign div.busy      = (state == st_iterate);
    assign div.done      = (state == st_finish);
    assign div.quotient  = eaq[DIV_WIDTH-1:0];
    assign div.remainder = eaq[2*DIV_WIDTH-1:DIV_WIDTH];

endmodule

// ==== divider_ifs.sv ====
`timescale 1ns/1ps

// Unsigned divider handshake, DIV_WIDTH wide
interface div_if #(
    parameter int DIV_WIDTH = fxp_pkg::DEFAULT_DATA_WIDTH + fxp_pkg::DEFAULT_QUANTIZED_BITS
);
    logic                 start;
    logic [DIV_WIDTH-1:0] dividend;
    logic [DIV_WIDTH-1:0] divisor;
    logic                 busy;
    logic                 done;
    logic [DIV_WIDTH-1:0] quotient;
    logic [DIV_WIDTH-1:0] remainder;

    modport master (output start, dividend, divisor,
                    input  busy, done, quotient, remainder);

    modport divider (input  start, dividend, divisor,
                     output busy, done, quotient, remainder);
endinterface

// Signed fixed-point request and result between registers and arithmetic
interface fxp_if #(
    parameter int DATA_WIDTH = fxp_pkg::DEFAULT_DATA_WIDTH
);
    logic                  start;
    logic [DATA_WIDTH-1:0] operand_a;
    logic [DATA_WIDTH-1:0] operand_b;
    logic                  busy;
    logic                  done;
    logic [DATA_WIDTH-1:0] result;
    logic [DATA_WIDTH-1:0] remainder;
    logic                  div_by_zero;
    logic                  saturated;

    modport registers (output start, operand_a, operand_b,
                       input  busy, done, result, remainder, div_by_zero, saturated);

    modport arith (input  start, operand_a, operand_b,
                   output busy, done, result, remainder, div_by_zero, saturated);
endinterface

// ==== fxp_divide.sv ====
`timescale 1ns/1ps

// Signed fixed-point division around the unsigned divider
module fxp_divide #(
    parameter int DATA_WIDTH     = fxp_pkg::DEFAULT_DATA_WIDTH,
    parameter int QUANTIZED_BITS = fxp_pkg::DEFAULT_QUANTIZED_BITS
)(
    input logic clock,
    input logic reset,
    fxp_if.arith fxp,
    div_if.master div
);

    localparam int DIV_WIDTH = DATA_WIDTH + QUANTIZED_BITS;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DIV_WIDTH-1:0]  div_word_t;

    localparam data_t MAX_VALUE = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    localparam data_t MIN_VALUE = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    typedef enum logic [1:0] {
        st_idle,
        st_launch,
        st_wait_div,
        st_done
    } state_t;

    state_t    state;
    logic      sign_q;          // Quotient sign
    logic      sign_r;          // Remainder sign, follows the dividend
    logic      zero_div;
    data_t     mag_a, mag_b;
    div_word_t dividend_q, divisor_q;
    data_t     result_q, remainder_q;
    logic      div_by_zero_q, saturated_q;
    logic      over;
    data_t     q_low, r_low, q_signed, r_signed;

    assign mag_a = fxp.operand_a[DATA_WIDTH-1] ? data_t'(-fxp.operand_a) : fxp.operand_a;
    assign mag_b = fxp.operand_b[DATA_WIDTH-1] ? data_t'(-fxp.operand_b) : fxp.operand_b;

    // ----------------------------------------
    // Sign restore and saturation
    // ----------------------------------------
    assign q_low = div.quotient[DATA_WIDTH-1:0];
    assign r_low = div.remainder[DATA_WIDTH-1:0];
    assign over  = sign_q ? (div.quotient > div_word_t'(MIN_VALUE))
                          : (div.quotient > div_word_t'(MAX_VALUE));

    always_comb begin
        if (over)
            q_signed = sign_q ? MIN_VALUE : MAX_VALUE;
        else
            q_signed = sign_q ? data_t'(-q_low) : q_low;
        r_signed = sign_r ? data_t'(-r_low) : r_low;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= st_idle;
            sign_q        <= 1'b0;
            sign_r        <= 1'b0;
            zero_div      <= 1'b0;
            result_q      <= '0;
            remainder_q   <= '0;
            div_by_zero_q <= 1'b0;
            saturated_q   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (fxp.start) begin
                        sign_q   <= fxp.operand_a[DATA_WIDTH-1] ^ fxp.operand_b[DATA_WIDTH-1];
                        sign_r   <= fxp.operand_a[DATA_WIDTH-1];
                        zero_div <= (fxp.operand_b == '0);
                        state    <= st_launch;
                    end
                end
                st_launch: begin
                    if (zero_div) begin     // Divider stays idle
                        result_q      <= sign_r ? MIN_VALUE : MAX_VALUE;
                        remainder_q   <= '0;
                        div_by_zero_q <= 1'b1;
                        saturated_q   <= 1'b0;
                        state         <= st_done;
                    end else begin
                        state <= st_wait_div;
                    end
                end
                st_wait_div: begin
                    if (div.done) begin
                        result_q      <= q_signed;
                        remainder_q   <= r_signed;
                        div_by_zero_q <= 1'b0;
                        saturated_q   <= over;
                        state         <= st_done;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Dividend magnitude pre-scaled by 2^QUANTIZED_BITS
    always_ff @(posedge clock) begin
        if (state == st_idle && fxp.start) begin
            dividend_q <= div_word_t'(mag_a) << QUANTIZED_BITS;
            divisor_q  <= div_word_t'(mag_b);
        end
    end

    assign div.start    = (state == st_launch) && !zero_div;
    assign div.dividend = dividend_q;
    assign div.divisor  = divisor_q;

    assign fxp.busy        = (state != st_idle);
    assign fxp.done        = (state == st_done);
    assign fxp.result      = result_q;
    assign fxp.remainder   = remainder_q;
    assign fxp.div_by_zero = div_by_zero_q;
    assign fxp.saturated   = saturated_q;

endmodule

// ==== fxp_pkg.sv ====
// Fixed-point arithmetic defaults and limits
package fxp_pkg;

    // ----------------------------------------
    // Operand format
    // ----------------------------------------

    // Total operand width in bits, sign bit included
    localparam int DEFAULT_DATA_WIDTH = 32;

    // Fraction bits of the Q format
    localparam int DEFAULT_QUANTIZED_BITS = 10;

    // ----------------------------------------
    // Limits
    // ----------------------------------------

    // An operand has to fit into one bus word
    localparam int MAX_DATA_WIDTH = 32;

endpackage

// ==== sim.f ====
fxp_pkg.sv
wb_map_pkg.sv
divider_ifs.sv
divide.sv
fxp_divide.sv
wb_div_regs.sv
wb_divider_top.sv
tb_wb_divider.sv

// ==== tb_wb_divider.sv ====
`timescale 1ns/1ps

module tb_wb_divider;

    localparam int DATA_WIDTH     = fxp_pkg::DEFAULT_DATA_WIDTH;
    localparam int QUANTIZED_BITS = fxp_pkg::DEFAULT_QUANTIZED_BITS;
    localparam int DIV_WIDTH      = DATA_WIDTH + QUANTIZED_BITS;
    localparam int CLOCK_PERIOD   = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int NUM_DIVISIONS  = 74;  // Directed and random divisions together
    localparam int BUS_CYCLES     = 24;  // Operand writes, polls and reads per division
    localparam longint TIMEOUT_NS =
        longint'(CLOCK_PERIOD) * (NUM_DIVISIONS * (DIV_WIDTH + 3 + BUS_CYCLES) + 200) * 2;
    localparam longint MAX_VALUE  = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
    localparam longint MIN_VALUE  = -(longint'(1) <<< (DATA_WIDTH - 1));

    logic        clock;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat_w;
    logic [31:0] dat_r;
    logic        ack;
    logic [31:0] lfsr;

    wb_divider_top #(
        .DATA_WIDTH     (DATA_WIDTH),
        .QUANTIZED_BITS (QUANTIZED_BITS)
    ) wb_divider_top_i (
        .clock (clock),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #TIMEOUT_NS;
        $display("Watchdog expired, the run timed out before all tests finished");
        $display("sim failed");
        $fatal(1, "Timeout");
    end

    // ----------------------------------------
    // Helpers and reference model
    // ----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};  // Taps 32,22,2,1
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    function automatic longint to_signed(input logic [31:0] word);
        longint value;
        value = longint'(word[DATA_WIDTH-1:0]);
        if (word[DATA_WIDTH-1])
            value = value - (longint'(1) <<< DATA_WIDTH);
        return value;
    endfunction

    function automatic logic [31:0] expected_status(input logic div_zero, input logic saturated);
        logic [31:0] word;
        word = '0;
        word[wb_map_pkg::STAT_DONE_BIT]      = 1'b1;  // Busy stays clear once done
        word[wb_map_pkg::STAT_DIV_ZERO_BIT]  = div_zero;
        word[wb_map_pkg::STAT_SATURATED_BIT] = saturated;
        return word;
    endfunction

    task automatic reference_div(input logic [31:0] a, input logic [31:0] b,
                                 output logic [31:0] quotient, output logic [31:0] remainder,
                                 output logic [31:0] status);
        longint sa;
        longint sb;
        longint num;
        longint q;
        logic   sat;
        sa  = to_signed(a);
        sb  = to_signed(b);
        sat = 1'b0;
        if (sb == 0) begin
            q         = (sa < 0) ? MIN_VALUE : MAX_VALUE;
            remainder = '0;
        end else begin
            num       = sa * (longint'(1) <<< QUANTIZED_BITS);
            q         = num / sb;            // Truncates toward zero
            remainder = 32'(num % sb);       // Takes the dividend's sign
            if (q > MAX_VALUE) begin
                q   = MAX_VALUE;
                sat = 1'b1;
            end else if (q < MIN_VALUE) begin
                q   = MIN_VALUE;
                sat = 1'b1;
            end
        end
        quotient = 32'(q);
        status   = expected_status(sb == 0, sat);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // ----------------------------------------
    // Wishbone and division tasks
    // ----------------------------------------
    task automatic wb_write(input wb_map_pkg::wb_addr_t reg_adr, input logic [31:0] data);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = {27'd0, reg_adr, 2'b00};
        dat_w = data;
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
        end while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_read(input wb_map_pkg::wb_addr_t reg_adr, output logic [31:0] data);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = {27'd0, reg_adr, 2'b00};
        do begin
            @(posedge clock);
            #DRIVE_DELAY;
        end while (!ack);
        data = dat_r;
        cyc  = 1'b0;
        stb  = 1'b0;
    endtask

    task automatic start_div(input logic [31:0] a, input logic [31:0] b);
        wb_write(wb_map_pkg::REG_OPERAND_A, a);
        wb_write(wb_map_pkg::REG_OPERAND_B, b);
        wb_write(wb_map_pkg::REG_CTRL_STATUS, 32'(1) << wb_map_pkg::CTRL_START_BIT);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        do begin
            wb_read(wb_map_pkg::REG_CTRL_STATUS, status);
        end while (!status[wb_map_pkg::STAT_DONE_BIT]);
    endtask

    task automatic read_and_check(input string name, input logic [31:0] quotient,
                                  input logic [31:0] remainder, input logic [31:0] status);
        logic [31:0] value;
        wb_read(wb_map_pkg::REG_RESULT, value);
        check({name, " quotient"}, quotient, value);
        wb_read(wb_map_pkg::REG_REMAINDER, value);
        check({name, " remainder"}, remainder, value);
        wb_read(wb_map_pkg::REG_CTRL_STATUS, value);
        check({name, " status"}, status, value);
    endtask

    task automatic div_expect(input string name, input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] quotient, input logic [31:0] remainder,
                              input logic [31:0] status);
        start_div(a, b);
        wait_done();
        read_and_check(name, quotient, remainder, status);
    endtask

    task automatic run_div(input string name, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] quotient;
        logic [31:0] remainder;
        logic [31:0] status;
        reference_div(a, b, quotient, remainder, status);
        div_expect(name, a, b, quotient, remainder, status);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_registers();
        logic [31:0] value;
        wb_read(wb_map_pkg::REG_CTRL_STATUS, value);
        check("reset status", 32'd0, value);
        wb_read(wb_map_pkg::REG_RESULT, value);
        check("reset result", 32'd0, value);
        wb_read(wb_map_pkg::REG_REMAINDER, value);
        check("reset remainder", 32'd0, value);
        wb_write(wb_map_pkg::REG_OPERAND_A, 32'hffff_f400);  // -3.0
        wb_read(wb_map_pkg::REG_OPERAND_A, value);
        check("operand a readback", 32'(to_signed(32'hffff_f400)), value);
        wb_write(wb_map_pkg::REG_OPERAND_B, 32'h0000_0600);  // 1.5
        wb_read(wb_map_pkg::REG_OPERAND_B, value);
        check("operand b readback", 32'(to_signed(32'h0000_0600)), value);
        wb_write(wb_map_pkg::REG_RESULT, 32'h1234_5678);
        wb_read(wb_map_pkg::REG_RESULT, value);
        check("result ignores write", 32'd0, value);
        wb_write(wb_map_pkg::REG_REMAINDER, 32'h8765_4321);
        wb_read(wb_map_pkg::REG_REMAINDER, value);
        check("remainder ignores write", 32'd0, value);
        wb_write(3'd5, 32'hffff_ffff);
        wb_read(3'd5, value);
        check("unmapped word", 32'd0, value);
    endtask

    task automatic test_exact();
        div_expect("3.0 / 1.5", 32'd3072, 32'd1536, 32'd2048, 32'd0, expected_status(0, 0));
        div_expect("1.0 / 3.0", 32'd1024, 32'd3072, 32'd341, 32'd1024, expected_status(0, 0));
        run_div("7.25 / 2.5", 32'd7424, 32'd2560);
    endtask

    task automatic test_signs();
        div_expect("-1.0 / 3.0", -32'd1024, 32'd3072, -32'd341, -32'd1024,
                   expected_status(0, 0));
        run_div("1.0 / 3.0 signed", 32'd1024, 32'd3072);
        run_div("1.0 / -3.0", 32'd1024, -32'd3072);
        run_div("-1.0 / -3.0", -32'd1024, -32'd3072);
        run_div("-7.5 / 2.25", -32'd7680, 32'd2304);
    endtask

    task automatic test_saturation();
        div_expect("large / tiny", 32'h4000_0000, 32'd1, 32'(MAX_VALUE), 32'd0,
                   expected_status(0, 1));
        div_expect("-large / tiny", 32'hc000_0000, 32'd1, 32'(MIN_VALUE), 32'd0,
                   expected_status(0, 1));
        div_expect("5.0 / 0", 32'd5120, 32'd0, 32'(MAX_VALUE), 32'd0, expected_status(1, 0));
        div_expect("-5.0 / 0", -32'd5120, 32'd0, 32'(MIN_VALUE), 32'd0, expected_status(1, 0));
        div_expect("0 / 0", 32'd0, 32'd0, 32'(MAX_VALUE), 32'd0, expected_status(1, 0));
    endtask

    task automatic test_busy_start();
        logic [31:0] value;
        logic [31:0] quotient;
        logic [31:0] remainder;
        logic [31:0] status;
        start_div(32'd5120, 32'd2048);  // 5.0 / 2.0
        wb_read(wb_map_pkg::REG_CTRL_STATUS, value);
        check("busy after start", 32'd1, {31'd0, value[wb_map_pkg::STAT_BUSY_BIT]});
        wb_write(wb_map_pkg::REG_OPERAND_A, 32'hffff_f000);
        wb_write(wb_map_pkg::REG_OPERAND_B, 32'd512);
        wb_write(wb_map_pkg::REG_CTRL_STATUS, 32'(1) << wb_map_pkg::CTRL_START_BIT);
        wait_done();
        reference_div(32'd5120, 32'd2048, quotient, remainder, status);
        read_and_check("start while busy", quotient, remainder, status);
        wb_read(wb_map_pkg::REG_OPERAND_A, value);
        check("operand a rewritten", 32'hffff_f000, value);
    endtask

    task automatic test_random();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] width;
        int          w;
        for (int i = 0; i < 60; i++) begin
            random_bits(DATA_WIDTH, a);
            random_bits(5, width);
            w = int'(width) + 1;  // Narrow divisors reach saturation and zero
            random_bits(w, b);
            if (b[w-1])
                b = b | ~((32'd1 << w) - 32'd1);
            run_div($sformatf("random %0d", i), a, b);
        end
    endtask

    initial begin
        lfsr  = 32'h8da6;
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        repeat (8) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        test_registers();
        test_exact();
        test_signs();
        test_saturation();
        test_busy_start();
        test_random();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== wb_div_regs.sv ====
`timescale 1ns/1ps

// Wishbone classic slave with operand, control/status and result registers
module wb_div_regs #(
    parameter int DATA_WIDTH = fxp_pkg::DEFAULT_DATA_WIDTH
)(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  wb_map_pkg::wb_addr_t adr,
    input  wb_map_pkg::wb_word_t dat_w,
    output wb_map_pkg::wb_word_t dat_r,
    output logic                 ack,
    fxp_if.registers fxp
);

    typedef logic [DATA_WIDTH-1:0] data_t;

    data_t operand_a, operand_b;
    data_t result_q, remainder_q;
    logic  done_q, div_zero_q, saturated_q;
    logic  start_q;
    logic  access;
    wb_map_pkg::wb_word_t status_word, read_word;

    function automatic wb_map_pkg::wb_word_t sign_extend(data_t value);
        logic signed [fxp_pkg::MAX_DATA_WIDTH-1:0] wide;
        wide = signed'(value);
        return wb_map_pkg::wb_word_t'(wide);
    endfunction

    assign access = cyc && stb && !ack;  // One access per classic cycle

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        status_word = '0;
        status_word[wb_map_pkg::STAT_BUSY_BIT]      = fxp.busy;  // Live
        status_word[wb_map_pkg::STAT_DONE_BIT]      = done_q;
        status_word[wb_map_pkg::STAT_DIV_ZERO_BIT]  = div_zero_q;
        status_word[wb_map_pkg::STAT_SATURATED_BIT] = saturated_q;
    end

    always_comb begin
        case (adr)
            wb_map_pkg::REG_OPERAND_A:   read_word = sign_extend(operand_a);
            wb_map_pkg::REG_OPERAND_B:   read_word = sign_extend(operand_b);
            wb_map_pkg::REG_CTRL_STATUS: read_word = status_word;
            wb_map_pkg::REG_RESULT:      read_word = sign_extend(result_q);
            wb_map_pkg::REG_REMAINDER:   read_word = sign_extend(remainder_q);
            default:                     read_word = '0;
        endcase
    end

    // ----------------------------------------
    // Bus cycles and register updates
    // ----------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ack         <= 1'b0;
            dat_r       <= '0;
            operand_a   <= '0;
            operand_b   <= '0;
            start_q     <= 1'b0;
            done_q      <= 1'b0;
            div_zero_q  <= 1'b0;
            saturated_q <= 1'b0;
            result_q    <= '0;
            remainder_q <= '0;
        end else begin
            ack     <= access;
            start_q <= 1'b0;
            if (access && !we)
                dat_r <= read_word;
            if (access && we) begin
                case (adr)
                    wb_map_pkg::REG_OPERAND_A: operand_a <= dat_w[DATA_WIDTH-1:0];
                    wb_map_pkg::REG_OPERAND_B: operand_b <= dat_w[DATA_WIDTH-1:0];
                    wb_map_pkg::REG_CTRL_STATUS: begin
                        if (dat_w[wb_map_pkg::CTRL_START_BIT] && !fxp.busy) begin
                            start_q <= 1'b1;
                            done_q  <= 1'b0;
                        end
                    end
                    default: ;  // Read-only and unmapped words
                endcase
            end
            if (fxp.done) begin
                result_q    <= fxp.result;
                remainder_q <= fxp.remainder;
                div_zero_q  <= fxp.div_by_zero;
                saturated_q <= fxp.saturated;
                done_q      <= 1'b1;
            end
        end
    end

    assign fxp.start     = start_q;
    assign fxp.operand_a = operand_a;
    assign fxp.operand_b = operand_b;

endmodule

// ==== wb_divider_top.sv ====
`timescale 1ns/1ps

// Fixed-point divide coprocessor on a Wishbone classic bus
module wb_divider_top #(
    parameter int DATA_WIDTH     = fxp_pkg::DEFAULT_DATA_WIDTH,
    parameter int QUANTIZED_BITS = fxp_pkg::DEFAULT_QUANTIZED_BITS
)(
    input  logic        clock,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);

    // Operands cannot be wider than a bus word
    localparam int OPERAND_WIDTH = (DATA_WIDTH > fxp_pkg::MAX_DATA_WIDTH) ?
                                   fxp_pkg::MAX_DATA_WIDTH : DATA_WIDTH;
    localparam int DIV_WIDTH     = OPERAND_WIDTH + QUANTIZED_BITS;

    wb_map_pkg::wb_addr_t word_adr;

    assign word_adr = adr[4:2];

    fxp_if #(.DATA_WIDTH(OPERAND_WIDTH)) fxp_bus ();
    div_if #(.DIV_WIDTH(DIV_WIDTH))      div_bus ();

    wb_div_regs #(.DATA_WIDTH(OPERAND_WIDTH)) wb_div_regs_i (
        .clock (clock),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (word_adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .fxp   (fxp_bus.registers)
    );

    fxp_divide #(
        .DATA_WIDTH     (OPERAND_WIDTH),
        .QUANTIZED_BITS (QUANTIZED_BITS)
    ) fxp_divide_i (
        .clock (clock),
        .reset (reset),
        .fxp   (fxp_bus.arith),
        .div   (div_bus.master)
    );

    divide #(.DIV_WIDTH(DIV_WIDTH)) divide_i (
        .clock (clock),
        .reset (reset),
        .div   (div_bus.divider)
    );

endmodule

// ==== wb_map_pkg.sv ====
// Wishbone word types and register map of the divider
package wb_map_pkg;

    typedef logic [31:0] wb_word_t;
    typedef logic [2:0]  wb_addr_t;   // Word address, adr[4:2]

    // ----------------------------------------
    // Register addresses
    // ----------------------------------------
    localparam wb_addr_t REG_OPERAND_A   = 3'd0;  // Dividend, read/write
    localparam wb_addr_t REG_OPERAND_B   = 3'd1;  // Divisor, read/write
    localparam wb_addr_t REG_CTRL_STATUS = 3'd2;
    localparam wb_addr_t REG_RESULT      = 3'd3;  // Quotient, read only
    localparam wb_addr_t REG_REMAINDER   = 3'd4;  // Read only

    // Control bits on write
    localparam int CTRL_START_BIT = 0;

    // Status bits on read
    localparam int STAT_BUSY_BIT      = 0;
    localparam int STAT_DONE_BIT      = 1;  // Sticky until next start
    localparam int STAT_DIV_ZERO_BIT  = 2;
    localparam int STAT_SATURATED_BIT = 3;

endpackage
